//--- project.f
+incdir+dv
design/rst_pkg.sv
design/rst_table_if.sv
design/rst_char_if.sv
design/rst_key_checker.sv
design/rst_table_keeper.sv
design/rst_char_indexer.sv
design/rst_encoder.sv
design/rst_cipher.sv
dv/tb_rst_cipher.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_rst_cipher -f project.f \
    -Mdir obj_dir -o sim_rst_cipher \
  && ./obj_dir/sim_rst_cipher > sim.log 2>&1 \
  ; cat sim.log 2>/dev/null \
  ; grep -qx "No errors" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- dv/rst_tb_tasks.svh
// compare tasks and directed tests for the cipher testbench
// stimulus changes on the falling edge, outputs sampled there too
`ifndef RST_TB_TASKS_SVH
`define RST_TB_TASKS_SVH

task automatic check_ctxt(input string test_name, input rst_ctxt_t exp, input rst_ctxt_t act);
  check_count++;
  if (act !== exp) begin
    err_count++;
    $display("FAIL %s: ctxt_str expected %h, actual %h", test_name, exp, act);
  end
endtask

task automatic check_flag(input string test_name, input string flag_name,
                          input logic exp, input logic act);
  check_count++;
  if (act !== exp) begin
    err_count++;
    $display("FAIL %s: %s expected %b, actual %b", test_name, flag_name, exp, act);
  end
endtask

task automatic expect_cipher(input string test_name, input rst_ctxt_t exp);
  if (ctxt_ready !== 1'b1) begin
    check_count++;
    err_count++;
    $display("%s: ctxt_ready did not rise in the cycle after an accepted character",
             test_name);
  end else begin
    check_ctxt(test_name, exp, ctxt_str);
  end
endtask

function automatic rst_char_t alnum_from_index(input int n);
  rst_char_t ch;
  if (n < 26) begin
    ch = rst_char_t'('h41 + n);
  end else if (n < 52) begin
    ch = rst_char_t'('h61 + n - 26);
  end else begin
    ch = rst_char_t'('h30 + n - 52);
  end
  return ch;
endfunction

// twelve distinct letters and digits
function automatic rst_key_t random_valid_key();
  rst_key_t k;
  bit       used [62];
  int       n;
  foreach (used[i]) used[i] = 1'b0;
  for (int i = 0; i < KEY_LEN; i++) begin
    do begin
      n = int'($urandom_range(61, 0));
    end while (used[n]);
    used[n] = 1'b1;
    k[i] = alnum_from_index(n);
  end
  return k;
endfunction

function automatic char_q_t random_alnum_string(input int len);
  char_q_t chars;
  for (int i = 0; i < len; i++) begin
    chars.push_back(alnum_from_index(int'($urandom_range(61, 0))));
  end
  return chars;
endfunction

// back-to-back requests, each result checked one cycle later
task automatic encrypt_stream(input string test_name, input char_q_t chars);
  rst_ctxt_t exp_prev;
  exp_prev = '0;
  for (int i = 0; i < chars.size(); i++) begin
    @(negedge clk);
    if (i > 0) begin
      expect_cipher(test_name, exp_prev);
    end
    ptxt_valid = 1'b1;
    ptxt_char  = chars[i];
    exp_prev   = encrypt_with_model(chars[i]);
  end
  @(negedge clk);
  expect_cipher(test_name, exp_prev);
  ptxt_valid = 1'b0;
  ptxt_char  = IDLE_CHAR;
endtask

task automatic reset_values_hold();
  check_ctxt("reset_values", '0, ctxt_str);
  check_flag("reset_values", "ctxt_ready", 1'b0, ctxt_ready);
  check_flag("reset_values", "err_invalid_ptxt_char", 1'b0, err_invalid_ptxt_char);
  check_flag("reset_values", "err_invalid_key", 1'b0, err_invalid_key);
  check_flag("reset_values", "key_not_installed", 1'b1, key_not_installed);
endtask

task automatic request_without_key();
  @(negedge clk);
  ptxt_valid = 1'b1;
  ptxt_char  = 8'h4b;
  @(negedge clk);
  check_flag("no_key_request", "ctxt_ready", 1'b0, ctxt_ready);
  check_flag("no_key_request", "key_not_installed", 1'b1, key_not_installed);
  check_flag("no_key_request", "err_invalid_key", 1'b1, err_invalid_key);
  ptxt_valid = 1'b0;
  ptxt_char  = IDLE_CHAR;
endtask

task automatic invalid_keys_rejected();
  rst_key_t k;
  k = random_valid_key();
  k[7] = k[2];
  @(negedge clk);
  key = k;
  @(negedge clk);
  check_flag("repeated_key", "err_invalid_key", 1'b1, err_invalid_key);
  // install state shows up one edge after the load
  @(negedge clk);
  check_flag("repeated_key", "key_not_installed", 1'b1, key_not_installed);
  k = random_valid_key();
  // hyphen is outside every accepted range
  k[4] = 8'h2d;
  key = k;
  @(negedge clk);
  check_flag("non_alnum_key", "err_invalid_key", 1'b1, err_invalid_key);
  @(negedge clk);
  check_flag("non_alnum_key", "key_not_installed", 1'b1, key_not_installed);
endtask

task automatic install_and_encrypt();
  installed_key = random_valid_key();
  key = installed_key;
  load_model_table(installed_key);
  @(negedge clk);
  check_flag("install", "err_invalid_key", 1'b0, err_invalid_key);
  check_flag("install", "key_not_installed", 1'b1, key_not_installed);
  @(negedge clk);
  check_flag("install", "key_not_installed", 1'b0, key_not_installed);
  encrypt_stream("install_encrypt", random_alnum_string(STRING_LEN));
endtask

// same letter in both cases, one rotation apart
task automatic case_folding();
  char_q_t chars;
  int      n;
  n = int'($urandom_range(25, 0));
  chars.push_back(alnum_from_index(n));
  chars.push_back(alnum_from_index(n + 26));
  encrypt_stream("case_folding", chars);
endtask

task automatic invalid_plaintext();
  char_q_t chars;
  @(negedge clk);
  ptxt_valid = 1'b1;
  ptxt_char  = 8'h23;
  @(negedge clk);
  check_flag("invalid_ptxt", "err_invalid_ptxt_char", 1'b1, err_invalid_ptxt_char);
  check_flag("invalid_ptxt", "ctxt_ready", 1'b0, ctxt_ready);
  ptxt_valid = 1'b0;
  ptxt_char  = IDLE_CHAR;
  // model untouched, so a match shows no rotation happened
  chars = random_alnum_string(1);
  encrypt_stream("invalid_ptxt", chars);
  check_flag("invalid_ptxt", "err_invalid_ptxt_char", 1'b0, err_invalid_ptxt_char);
endtask

task automatic key_lock();
  rst_key_t new_key;
  do begin
    new_key = random_valid_key();
  end while (new_key == installed_key);
  @(negedge clk);
  key = new_key;
  repeat (2) @(negedge clk);
  check_flag("key_lock", "err_invalid_key", 1'b0, err_invalid_key);
  check_flag("key_lock", "key_not_installed", 1'b0, key_not_installed);
  encrypt_stream("key_lock", random_alnum_string(LOCK_LEN));
endtask

`endif

//--- dv/tb_rst_cipher.sv
// testbench top for the rotary substitution table cipher
// clock, reset, DUT, watchdog and software reference table
// directed tests come from the included task file
`timescale 1ns/100ps

module tb_rst_cipher;
  import rst_pkg::*;

  typedef rst_char_t char_q_t[$];

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 16;
  localparam int STRING_LEN   = 24;
  localparam int LOCK_LEN     = 12;
  // cycles of all directed tests with some slack per test
  localparam int TEST_CYCLES  = RESET_CYCLES + STRING_LEN + LOCK_LEN + 7 * 6;
  localparam logic [31:0] SEED = 32'hd9b9;
  localparam rst_char_t IDLE_CHAR = 8'h41;

  // key positions feeding row and column entries at load
  localparam int unsigned LOAD_ROW_POS [TABLE_SIDE] = '{11, 1, 9, 3, 7, 5};
  localparam int unsigned LOAD_COL_POS [TABLE_SIDE] = '{10, 0, 8, 2, 6, 4};

  logic      clk;
  logic      rst_n;
  logic      ptxt_valid;
  rst_char_t ptxt_char;
  rst_key_t  key;
  rst_ctxt_t ctxt_str;
  logic      ctxt_ready;
  logic      err_invalid_ptxt_char;
  logic      err_invalid_key;
  logic      key_not_installed;

  int        err_count;
  int        check_count;
  rst_key_t  installed_key;
  rst_char_t model_rows [TABLE_SIDE];
  rst_char_t model_cols [TABLE_SIDE];

  rst_cipher uut (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .ptxt_valid            (ptxt_valid),
    .ptxt_char             (ptxt_char),
    .key                   (key),
    .ctxt_str              (ctxt_str),
    .ctxt_ready            (ctxt_ready),
    .err_invalid_ptxt_char (err_invalid_ptxt_char),
    .err_invalid_key       (err_invalid_key),
    .key_not_installed     (key_not_installed)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // letters in either case at their alphabet offset, digits after them
  function automatic int char_position(input rst_char_t ch);
    int pos;
    if (ch >= 8'h61) begin
      pos = int'(ch) - 'h61;
    end else if (ch >= 8'h41) begin
      pos = int'(ch) - 'h41;
    end else begin
      pos = 26 + int'(ch) - 'h30;
    end
    return pos;
  endfunction

  function automatic void load_model_table(input rst_key_t k);
    for (int i = 0; i < TABLE_SIDE; i++) begin
      model_rows[i] = k[LOAD_ROW_POS[i]];
      model_cols[i] = k[LOAD_COL_POS[i]];
    end
  endfunction

  // pair from the current table, then one step toward the higher index
  function automatic rst_ctxt_t encrypt_with_model(input rst_char_t ch);
    int        pos;
    rst_ctxt_t res;
    rst_char_t last_row;
    rst_char_t last_col;
    pos = char_position(ch);
    res = {model_rows[pos / TABLE_SIDE], model_cols[pos % TABLE_SIDE]};
    last_row = model_rows[TABLE_SIDE-1];
    last_col = model_cols[TABLE_SIDE-1];
    for (int i = TABLE_SIDE - 1; i > 0; i--) begin
      model_rows[i] = model_rows[i-1];
      model_cols[i] = model_cols[i-1];
    end
    model_rows[0] = last_row;
    model_cols[0] = last_col;
    return res;
  endfunction

  `include "rst_tb_tasks.svh"

  initial begin
    #(TEST_CYCLES * CLK_PERIOD * 2);
    $display("watchdog expired after %0d ns, tests did not finish",
             TEST_CYCLES * CLK_PERIOD * 2);
    $display("Errors found");
    $finish;
  end

  initial begin
    rst_n       = 1'b0;
    ptxt_valid  = 1'b0;
    ptxt_char   = IDLE_CHAR;
    key         = '0;
    err_count   = 0;
    check_count = 0;
    void'($urandom(SEED));
    repeat (RESET_CYCLES) @(negedge clk);
    reset_values_hold();
    rst_n = 1'b1;
    request_without_key();
    invalid_keys_rejected();
    install_and_encrypt();
    case_folding();
    invalid_plaintext();
    key_lock();
    $display("checks %0d, errors %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- design/rst_cipher.sv
// rotary substitution table cipher, encrypt side
// top level with plain ports
// table keeper and character indexer feed the encoder
`timescale 1ns/100ps

module rst_cipher (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               ptxt_valid,
  input  rst_pkg::rst_char_t ptxt_char,
  input  rst_pkg::rst_key_t  key,
  output rst_pkg::rst_ctxt_t ctxt_str,
  output logic               ctxt_ready,
  output logic               err_invalid_ptxt_char,
  output logic               err_invalid_key,
  output logic               key_not_installed
);

  rst_table_if tbl_if ();
  rst_char_if  char_if ();

  rst_table_keeper u_table_keeper (
    .clk             (clk),
    .rst_n           (rst_n),
    .key             (key),
    .tbl             (tbl_if.keeper),
    .err_invalid_key (err_invalid_key)
  );

  rst_char_indexer u_char_indexer (
    .ptxt_valid (ptxt_valid),
    .ptxt_char  (ptxt_char),
    .idx        (char_if.indexer)
  );

  rst_encoder u_encoder (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .tbl                   (tbl_if.encoder),
    .idx                   (char_if.encoder),
    .ctxt_str              (ctxt_str),
    .ctxt_ready            (ctxt_ready),
    .err_invalid_ptxt_char (err_invalid_ptxt_char),
    .key_not_installed     (key_not_installed)
  );

endmodule

//--- design/rst_encoder.sv
// encoder
// selects the row and column pair for an accepted character
// requests a table rotation on the same edge
// registered ciphertext, ready and status flags
`timescale 1ns/100ps

module rst_encoder (
  input  logic               clk,
  input  logic               rst_n,
  rst_table_if.encoder       tbl,
  rst_char_if.encoder        idx,
  output rst_pkg::rst_ctxt_t ctxt_str,
  output logic               ctxt_ready,
  output logic               err_invalid_ptxt_char,
  output logic               key_not_installed
);

  logic        accept;
  logic [15:0] pair;

  // valid alphanumeric request against a loaded table
  assign accept = idx.alnum_req && tbl.loaded;

  assign pair = {tbl.rows[idx.row], tbl.cols[idx.col]};

  // rotation takes effect at the edge that registers this result
  assign tbl.advance = accept;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctxt_str              <= '0;
      ctxt_ready            <= 1'b0;
      err_invalid_ptxt_char <= 1'b0;
      key_not_installed     <= 1'b1;
    end else begin
      ctxt_ready <= accept;
      if (accept) begin
        ctxt_str <= pair;
      end else begin
        ctxt_str <= '0;
      end
      // flagged regardless of ptxt_valid
      err_invalid_ptxt_char <= !idx.char_ok;
      key_not_installed     <= !tbl.loaded;
    end
  end

endmodule

//--- design/rst_char_indexer.sv
// character indexer
// classifies the plaintext character and maps it to
// a row and column of the substitution table
`timescale 1ns/100ps

module rst_char_indexer (
  input  logic               ptxt_valid,
  input  rst_pkg::rst_char_t ptxt_char,
  rst_char_if.indexer        idx
);
  import rst_pkg::*;

  rst_char_class_e cls;
  rst_char_t       pos;
  logic            char_ok;

  assign cls = classify_char(ptxt_char);

  // linear position 0..35, case folded
  always_comb begin
    case (cls)
      CHAR_UPPER: pos = ptxt_char - UPPER_A;
      CHAR_LOWER: pos = ptxt_char - LOWER_A;
      CHAR_DIGIT: pos = ptxt_char - DIGIT_0 + rst_char_t'(LETTER_COUNT);
      default:    pos = '0;
    endcase
  end

  assign char_ok = (cls != CHAR_INVALID);

  assign idx.char_ok   = char_ok;
  assign idx.alnum_req = ptxt_valid && char_ok;
  assign idx.row       = rst_idx_t'(pos / TABLE_SIDE);
  assign idx.col       = rst_idx_t'(pos % TABLE_SIDE);

endmodule

//--- design/rst_table_keeper.sv
// table keeper
// one-time load from the first valid key
// cyclic rotation of rows and columns per accepted character
`timescale 1ns/100ps

module rst_table_keeper (
  input  logic              clk,
  input  logic              rst_n,
  input  rst_pkg::rst_key_t key,
  rst_table_if.keeper       tbl,
  output logic              err_invalid_key
);
  import rst_pkg::*;

  rst_table_state_e state;
  rst_table_state_e state_next;
  logic             key_ok;
  logic             do_load;
  logic             do_rotate;

  rst_char_t [TABLE_SIDE-1:0] rows_q;
  rst_char_t [TABLE_SIDE-1:0] cols_q;

  rst_key_checker u_key_checker (
    .clk             (clk),
    .rst_n           (rst_n),
    .key             (key),
    .key_ok          (key_ok),
    .err_invalid_key (err_invalid_key)
  );

  assign do_load   = (state == TABLE_EMPTY) && key_ok;
  assign do_rotate = (state == TABLE_LOADED) && tbl.advance;

  always_comb begin
    state_next = state;
    case (state)
      TABLE_EMPTY: begin
        if (key_ok) begin
          state_next = TABLE_LOADED;
        end
      end
      // later keys are ignored until reset
      TABLE_LOADED: state_next = TABLE_LOADED;
      default: state_next = TABLE_EMPTY;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= TABLE_EMPTY;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk) begin
    if (do_load) begin
      for (int i = 0; i < TABLE_SIDE; i++) begin
        rows_q[i] <= key[ROW_KEY_POS[i]];
        cols_q[i] <= key[COL_KEY_POS[i]];
      end
    end else if (do_rotate) begin
      // entry i moves to i+1, last wraps to 0
      rows_q <= {rows_q[TABLE_SIDE-2:0], rows_q[TABLE_SIDE-1]};
      cols_q <= {cols_q[TABLE_SIDE-2:0], cols_q[TABLE_SIDE-1]};
    end
  end

  assign tbl.rows   = rows_q;
  assign tbl.cols   = cols_q;
  assign tbl.loaded = (state == TABLE_LOADED);

endmodule

//--- design/rst_key_checker.sv
// key checker
// every character alphanumeric and no repeats
// combinational key_ok plus registered invalid key flag
`timescale 1ns/100ps

module rst_key_checker (
  input  logic             clk,
  input  logic             rst_n,
  input  rst_pkg::rst_key_t key,
  output logic             key_ok,
  output logic             err_invalid_key
);
  import rst_pkg::*;

  logic all_alnum;
  logic dup_found;

  always_comb begin
    all_alnum = 1'b1;
    dup_found = 1'b0;
    for (int i = 0; i < KEY_LEN; i++) begin
      if (classify_char(key[i]) == CHAR_INVALID) begin
        all_alnum = 1'b0;
      end
      // each pair compared once
      for (int j = i + 1; j < KEY_LEN; j++) begin
        if (key[i] == key[j]) begin
          dup_found = 1'b1;
        end
      end
    end
  end

  assign key_ok = all_alnum && !dup_found;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_invalid_key <= 1'b0;
    end else begin
      err_invalid_key <= !key_ok;
    end
  end

endmodule

//--- design/rst_char_if.sv
// indexed plaintext interface, indexer to encoder
// combinational within a cycle
`timescale 1ns/100ps

interface rst_char_if;
  import rst_pkg::*;

  logic     char_ok;
  logic     alnum_req;
  rst_idx_t row;
  rst_idx_t col;

  modport indexer (
    output char_ok,
    output alnum_req,
    output row,
    output col
  );

  modport encoder (
    input char_ok,
    input alnum_req,
    input row,
    input col
  );

endinterface

//--- design/rst_table_if.sv
// table interface between table keeper and encoder
// carries row and column characters, install state
// and the rotate request back from the encoder
`timescale 1ns/100ps

interface rst_table_if;
  import rst_pkg::*;

  rst_char_t [TABLE_SIDE-1:0] rows;
  rst_char_t [TABLE_SIDE-1:0] cols;
  logic                       loaded;
  // sampled at the clock edge, rotates once when loaded
  logic                       advance;

  modport keeper (
    output rows,
    output cols,
    output loaded,
    input  advance
  );

  modport encoder (
    input  rows,
    input  cols,
    input  loaded,
    output advance
  );

endinterface

//--- design/rst_pkg.sv
// shared types for the rotary substitution table cipher
// character, key, ciphertext and index types
// character class and table state enums
// ascii bounds, table geometry and key load map
// character classifier
package rst_pkg;

  localparam int unsigned KEY_LEN      = 12;
  localparam int unsigned TABLE_SIDE   = 6;
  // digits follow the letters in the linear position
  localparam int unsigned LETTER_COUNT = 26;

  typedef logic [7:0] rst_char_t;
  typedef rst_char_t [KEY_LEN-1:0] rst_key_t;
  // row character high, column character low
  typedef logic [15:0] rst_ctxt_t;
  typedef logic [2:0] rst_idx_t;

  typedef enum logic [1:0] {
    CHAR_INVALID = 2'd0,
    CHAR_UPPER   = 2'd1,
    CHAR_LOWER   = 2'd2,
    CHAR_DIGIT   = 2'd3
  } rst_char_class_e;

  typedef enum logic {
    TABLE_EMPTY  = 1'b0,
    TABLE_LOADED = 1'b1
  } rst_table_state_e;

  localparam rst_char_t UPPER_A = 8'h41;
  localparam rst_char_t UPPER_Z = 8'h5a;
  localparam rst_char_t LOWER_A = 8'h61;
  localparam rst_char_t LOWER_Z = 8'h7a;
  localparam rst_char_t DIGIT_0 = 8'h30;
  localparam rst_char_t DIGIT_9 = 8'h39;

  // key character feeding each table entry at load
  localparam int unsigned ROW_KEY_POS [TABLE_SIDE] = '{11, 1, 9, 3, 7, 5};
  localparam int unsigned COL_KEY_POS [TABLE_SIDE] = '{10, 0, 8, 2, 6, 4};

  function automatic rst_char_class_e classify_char(input rst_char_t ch);
    rst_char_class_e cls;
    if (ch >= UPPER_A && ch <= UPPER_Z) begin
      cls = CHAR_UPPER;
    end else if (ch >= LOWER_A && ch <= LOWER_Z) begin
      cls = CHAR_LOWER;
    end else if (ch >= DIGIT_0 && ch <= DIGIT_9) begin
      cls = CHAR_DIGIT;
    end else begin
      cls = CHAR_INVALID;
    end
    return cls;
  endfunction

endpackage
